//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := core_tb
FILELIST  := core_top.f
PASS_MSG  := PASS: all tests

SRCS := $(shell cat $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- core_top.f
hdl/core_pkg.sv
hdl/core_fetch.sv
hdl/core_decode.sv
hdl/core_regfile.sv
hdl/core_execute.sv
hdl/core_top.sv
sim/core_assertions.sv
sim/core_tb.sv

//--- hdl/core_decode.sv
/*
 * Decode stage
 * Union view selection, immediates, ALU op mapping,
 * EX to ID forwarding, ID/EX register
 */
`timescale 1ns/1ps

module core_decode (
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  core_pkg::if_id_t   if_id_i,
  output logic               id_ready_o,

  // Register file read ports
  output core_pkg::rf_addr_t rs1_addr_o,
  output core_pkg::rf_addr_t rs2_addr_o,
  input  core_pkg::word_t    rs1_data_i,
  input  core_pkg::word_t    rs2_data_i,

  // Write from execute, same cycle
  input  logic               fwd_we_i,
  input  core_pkg::rf_addr_t fwd_waddr_i,
  input  core_pkg::word_t    fwd_wdata_i,

  input  logic               ex_ready_i,
  output core_pkg::id_ex_t   id_ex_o
);

  import core_pkg::*;

  instr_u  instr;
  id_ex_t  id_ex_d;
  id_ex_t  id_ex_q;
  word_t   rs1_val;
  word_t   rs2_val;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_u;
  logic    rs1_fwd;
  logic    rs2_fwd;
  alu_op_e f3_op;
  logic    f3_ok;

  assign instr = if_id_i.instr;

  // rs1 and rs2 sit at the same bits in R and S format
  assign rs1_addr_o = instr.r_type.rs1;
  assign rs2_addr_o = instr.r_type.rs2;

  ////////////////////////////////////////
  // Operand forwarding
  ////////////////////////////////////////

  // x0 never forwarded
  assign rs1_fwd = fwd_we_i & (fwd_waddr_i == instr.r_type.rs1) & (instr.r_type.rs1 != '0);
  assign rs2_fwd = fwd_we_i & (fwd_waddr_i == instr.r_type.rs2) & (instr.r_type.rs2 != '0);

  assign rs1_val = rs1_fwd ? fwd_wdata_i : rs1_data_i;
  assign rs2_val = rs2_fwd ? fwd_wdata_i : rs2_data_i;

  // Sign extended I and S immediates
  assign imm_i = {{(XLEN-12){instr.i_type.imm[11]}}, instr.i_type.imm};
  assign imm_s = {{(XLEN-12){instr.s_type.imm_hi[6]}}, instr.s_type.imm_hi,
                  instr.s_type.imm_lo};
  // LUI upper 20 bits span imm, rs1 and funct3 of the I view
  assign imm_u = {instr.i_type.imm, instr.i_type.rs1, instr.i_type.funct3, 12'b0};

  // funct3 mapping shared by OP and OP_IMM
  always_comb begin
    f3_ok = 1'b1;
    case (instr.i_type.funct3)
      FUNCT3_ADD: f3_op = ALU_ADD;
      FUNCT3_XOR: f3_op = ALU_XOR;
      FUNCT3_OR:  f3_op = ALU_OR;
      FUNCT3_AND: f3_op = ALU_AND;
      default: begin
        f3_op = ALU_ADD;
        f3_ok = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////
  // Main decoder
  ////////////////////////////////////////

  always_comb begin
    id_ex_d            = '0;
    id_ex_d.valid      = if_id_i.valid;
    id_ex_d.alu_op     = ALU_ADD;
    id_ex_d.operand_a  = rs1_val;
    id_ex_d.operand_b  = rs2_val;
    id_ex_d.store_data = rs2_val;
    id_ex_d.rd         = instr.r_type.rd;
    case (instr.r_type.opcode)
      OPC_OP: begin
        if (instr.r_type.funct7 == FUNCT7_SUB && instr.r_type.funct3 == FUNCT3_ADD) begin
          id_ex_d.alu_op = ALU_SUB;
          id_ex_d.rf_we  = 1'b1;
        end else if (instr.r_type.funct7 == '0) begin
          id_ex_d.alu_op = f3_op;
          id_ex_d.rf_we  = f3_ok;
        end
      end
      OPC_OP_IMM: begin
        id_ex_d.alu_op    = f3_op;
        id_ex_d.operand_b = imm_i;
        id_ex_d.rf_we     = f3_ok;
      end
      OPC_LUI: begin
        id_ex_d.alu_op    = ALU_PASS_B;
        id_ex_d.operand_b = imm_u;
        id_ex_d.rf_we     = 1'b1;
      end
      OPC_STORE: begin
        // Address is rs1 plus S immediate
        if (instr.s_type.funct3 == FUNCT3_SW) begin
          id_ex_d.operand_b = imm_s;
          id_ex_d.is_store  = 1'b1;
        end
      end
      // Anything else passes through as a no-op
      default: ;
    endcase
  end

  // One instruction per stage, so decode moves with execute
  assign id_ready_o = ex_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      id_ex_q.valid <= 1'b0;
    end else if (ex_ready_i) begin
      id_ex_q <= id_ex_d;
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

//--- hdl/core_execute.sv
/*
 * Execute stage with folded write-back
 * ALU, register file write, Wishbone classic store master
 */
`timescale 1ns/1ps

module core_execute (
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  core_pkg::id_ex_t   id_ex_i,
  output logic               ex_ready_o,

  // Data bus, word stores only
  output core_pkg::wb_req_t  dbus_req_o,
  input  core_pkg::wb_rsp_t  dbus_rsp_i,

  // Register file write, also the forwarding source
  output logic               rf_we_o,
  output core_pkg::rf_addr_t rf_waddr_o,
  output core_pkg::word_t    rf_wdata_o
);

  import core_pkg::*;

  word_t alu_result;
  logic  store_pending;
  logic  dbus_ack;
  logic  store_done_q;

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  // Also the store address adder
  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD:    alu_result = id_ex_i.operand_a + id_ex_i.operand_b;
      ALU_SUB:    alu_result = id_ex_i.operand_a - id_ex_i.operand_b;
      ALU_AND:    alu_result = id_ex_i.operand_a & id_ex_i.operand_b;
      ALU_OR:     alu_result = id_ex_i.operand_a | id_ex_i.operand_b;
      ALU_XOR:    alu_result = id_ex_i.operand_a ^ id_ex_i.operand_b;
      ALU_PASS_B: alu_result = id_ex_i.operand_b;
      default:    alu_result = '0;
    endcase
  end

  ////////////////////////////////////////
  // Store master
  ////////////////////////////////////////

  // Store waiting for ack
  // Masked for one cycle after an ack so cyc drops between stores
  assign store_pending = id_ex_i.valid & id_ex_i.is_store & ~store_done_q;
  assign dbus_ack      = store_pending & dbus_rsp_i.ack;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      store_done_q <= 1'b0;
    end else begin
      store_done_q <= dbus_ack;
    end
  end

  // Request comes straight from ID/EX, stable while the stage is held
  always_comb begin
    dbus_req_o     = '0;
    dbus_req_o.cyc = store_pending;
    dbus_req_o.stb = store_pending;
    dbus_req_o.we  = 1'b1;
    dbus_req_o.adr = alu_result;
    dbus_req_o.dat = id_ex_i.store_data;
    dbus_req_o.sel = 4'hF;
  end

  // Empty or ALU op leaves at once, a store only with its ack
  assign ex_ready_o = ~id_ex_i.valid | ~id_ex_i.is_store | dbus_ack;

  ////////////////////////////////////////
  // Write-back
  ////////////////////////////////////////

  // Written on the edge the instruction leaves execute
  assign rf_we_o    = id_ex_i.valid & id_ex_i.rf_we & ~id_ex_i.is_store;
  assign rf_waddr_o = id_ex_i.rd;
  assign rf_wdata_o = alu_result;

endmodule

//--- hdl/core_fetch.sv
/*
 * Instruction fetch stage
 * Sequential program counter, Wishbone classic read master, IF/ID register
 */
`timescale 1ns/1ps

module core_fetch (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              fetch_enable_i,

  // Instruction bus
  output core_pkg::wb_req_t ibus_req_o,
  input  core_pkg::wb_rsp_t ibus_rsp_i,

  // Towards decode
  input  logic              id_ready_i,
  output core_pkg::if_id_t  if_id_o
);

  import core_pkg::*;

  word_t  pc_q;
  logic   cyc_q;
  if_id_t if_id_q;
  logic   fetch_ack;
  logic   fetch_start;

  // Transfer ends on the edge that sees ack
  assign fetch_ack = cyc_q & ibus_rsp_i.ack;

  // New read only if IF/ID is empty or drains on this edge
  // The cyc_q term keeps one idle cycle after every ack
  assign fetch_start = ~cyc_q & fetch_enable_i & (~if_id_q.valid | id_ready_i);

  ////////////////////////////////////////
  // PC and bus cycle
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cyc_q <= 1'b0;
      pc_q  <= BOOT_ADDR;
    end else begin
      if (fetch_start) begin
        cyc_q <= 1'b1;
      end else if (fetch_ack) begin
        cyc_q <= 1'b0;
      end
      // Strictly sequential, no branches
      if (fetch_ack) begin
        pc_q <= pc_q + XLEN'(4);
      end
    end
  end

  // Read only, full word, request held until ack
  always_comb begin
    ibus_req_o     = '0;
    ibus_req_o.cyc = cyc_q;
    ibus_req_o.stb = cyc_q;
    ibus_req_o.we  = 1'b0;
    ibus_req_o.adr = pc_q;
    ibus_req_o.sel = 4'hF;
  end

  ////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////

  // IF/ID is always empty by the time ack comes back
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      if_id_q.valid <= 1'b0;
    end else if (fetch_ack) begin
      if_id_q.valid <= 1'b1;
      if_id_q.instr <= ibus_rsp_i.dat;
    end else if (id_ready_i) begin
      // Decode took the word
      if_id_q.valid <= 1'b0;
    end
  end

  assign if_id_o = if_id_q;

endmodule

//--- hdl/core_pkg.sv
/*
 * Shared definitions of the RV32I integer core
 * Widths, boot address, opcodes and function codes, ALU operations,
 * Wishbone request and response structs, instruction union, pipeline registers
 */
package core_pkg;

  ////////////////////////////////////////
  // Widths and addresses
  ////////////////////////////////////////

  localparam int unsigned XLEN      = 32;
  localparam int unsigned RF_ADDR_W = 5;
  // First fetch address after reset
  localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_0000;

  ////////////////////////////////////////
  // Encodings of the supported subset
  ////////////////////////////////////////

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // funct3, shared by OP and OP_IMM
  localparam logic [2:0] FUNCT3_ADD = 3'b000;
  localparam logic [2:0] FUNCT3_XOR = 3'b100;
  localparam logic [2:0] FUNCT3_OR  = 3'b110;
  localparam logic [2:0] FUNCT3_AND = 3'b111;
  // Word store
  localparam logic [2:0] FUNCT3_SW  = 3'b010;

  // SUB marker in funct7
  localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  typedef logic [RF_ADDR_W-1:0] rf_addr_t;
  typedef logic [XLEN-1:0]      word_t;

  ////////////////////////////////////////
  // Wishbone classic
  ////////////////////////////////////////

  // Master request, 71 bits
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    word_t      adr;
    word_t      dat;
    logic [3:0] sel;
  } wb_req_t;

  // Slave response, 33 bits
  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

  ////////////////////////////////////////
  // Instruction word and pipeline
  ////////////////////////////////////////

  // Same 32 bits seen as R, I or S format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      rf_addr_t   rs2;
      rf_addr_t   rs1;
      logic [2:0] funct3;
      rf_addr_t   rd;
      logic [6:0] opcode;
    } r_type;
    struct packed {
      logic [11:0] imm;
      rf_addr_t    rs1;
      logic [2:0]  funct3;
      rf_addr_t    rd;
      logic [6:0]  opcode;
    } i_type;
    struct packed {
      logic [6:0] imm_hi;
      rf_addr_t   rs2;
      rf_addr_t   rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_type;
  } instr_u;

  // IF/ID register
  typedef struct packed {
    logic   valid;
    instr_u instr;
  } if_id_t;

  // ID/EX register, operands already resolved
  typedef struct packed {
    logic     valid;
    alu_op_e  alu_op;
    word_t    operand_a;
    word_t    operand_b;
    word_t    store_data;
    rf_addr_t rd;
    logic     rf_we;
    logic     is_store;
  } id_ex_t;

endpackage

//--- hdl/core_regfile.sv
/*
 * Integer register file
 * x1 to x31, two asynchronous read ports, one write port, x0 reads zero
 */
`timescale 1ns/1ps

module core_regfile (
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  core_pkg::rf_addr_t raddr_a_i,
  input  core_pkg::rf_addr_t raddr_b_i,
  output core_pkg::word_t    rdata_a_o,
  output core_pkg::word_t    rdata_b_o,

  input  logic               we_i,
  input  core_pkg::rf_addr_t waddr_i,
  input  core_pkg::word_t    wdata_i
);

  import core_pkg::*;

  localparam int unsigned NUM_REGS = 2 ** RF_ADDR_W;

  // No storage behind x0
  word_t regs_q [1:NUM_REGS-1];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Index 0 is hardwired zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- hdl/core_top.sv
/*
 * Top level of the RV32I integer core
 * Fetch, decode, execute and the register file
 */
`timescale 1ns/1ps

module core_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              fetch_enable_i,

  // Instruction bus
  output core_pkg::wb_req_t ibus_req_o,
  input  core_pkg::wb_rsp_t ibus_rsp_i,

  // Data bus
  output core_pkg::wb_req_t dbus_req_o,
  input  core_pkg::wb_rsp_t dbus_rsp_i
);

  import core_pkg::*;

  // Pipeline registers
  if_id_t   if_id;
  id_ex_t   id_ex;

  // Stage handshakes
  logic     id_ready;
  logic     ex_ready;

  // Register file reads from decode
  rf_addr_t rs1_addr;
  rf_addr_t rs2_addr;
  word_t    rs1_data;
  word_t    rs2_data;

  // Register file write from execute, forwarded to decode
  logic     rf_we;
  rf_addr_t rf_waddr;
  word_t    rf_wdata;

  ////////////////////////////////////////
  // Fetch
  ////////////////////////////////////////

  core_fetch fetch_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .ibus_req_o     ( ibus_req_o     ),
    .ibus_rsp_i     ( ibus_rsp_i     ),
    .id_ready_i     ( id_ready       ),
    .if_id_o        ( if_id          )
  );

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  core_decode decode_i (
    .clk_i       ( clk_i    ),
    .rst_n_i     ( rst_n_i  ),
    .if_id_i     ( if_id    ),
    .id_ready_o  ( id_ready ),
    .rs1_addr_o  ( rs1_addr ),
    .rs2_addr_o  ( rs2_addr ),
    .rs1_data_i  ( rs1_data ),
    .rs2_data_i  ( rs2_data ),
    .fwd_we_i    ( rf_we    ),
    .fwd_waddr_i ( rf_waddr ),
    .fwd_wdata_i ( rf_wdata ),
    .ex_ready_i  ( ex_ready ),
    .id_ex_o     ( id_ex    )
  );

  core_regfile regfile_i (
    .clk_i     ( clk_i    ),
    .rst_n_i   ( rst_n_i  ),
    .raddr_a_i ( rs1_addr ),
    .raddr_b_i ( rs2_addr ),
    .rdata_a_o ( rs1_data ),
    .rdata_b_o ( rs2_data ),
    .we_i      ( rf_we    ),
    .waddr_i   ( rf_waddr ),
    .wdata_i   ( rf_wdata )
  );

  ////////////////////////////////////////
  // Execute and write-back
  ////////////////////////////////////////

  core_execute execute_i (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .id_ex_i    ( id_ex      ),
    .ex_ready_o ( ex_ready   ),
    .dbus_req_o ( dbus_req_o ),
    .dbus_rsp_i ( dbus_rsp_i ),
    .rf_we_o    ( rf_we      ),
    .rf_waddr_o ( rf_waddr   ),
    .rf_wdata_o ( rf_wdata   )
  );

endmodule

//--- sim/core_assertions.sv
/*
 * Wishbone classic protocol assertions for the instruction and data bus
 */
`timescale 1ns/1ps

module core_assertions (
  input logic              clk_i,
  input logic              rst_n_i,
  input core_pkg::wb_req_t ibus_req_o,
  input core_pkg::wb_rsp_t ibus_rsp_i,
  input core_pkg::wb_req_t dbus_req_o,
  input core_pkg::wb_rsp_t dbus_rsp_i
);

  // stb only inside a cycle
  ibus_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ibus_req_o.stb |-> ibus_req_o.cyc) else $error("ibus stb without cyc");
  dbus_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dbus_req_o.stb |-> dbus_req_o.cyc) else $error("dbus stb without cyc");

  // Request held until ack
  ibus_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ibus_req_o.cyc && !ibus_rsp_i.ack) |=> (ibus_req_o == $past(ibus_req_o)))
    else $error("ibus request changed while waiting");
  dbus_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (dbus_req_o.cyc && !dbus_rsp_i.ack) |=> (dbus_req_o == $past(dbus_req_o)))
    else $error("dbus request changed while waiting");

  // One idle cycle after each transfer
  ibus_cyc_drop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ibus_req_o.cyc && ibus_rsp_i.ack) |=> !ibus_req_o.cyc)
    else $error("ibus cyc held after ack");
  dbus_cyc_drop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (dbus_req_o.cyc && dbus_rsp_i.ack) |=> !dbus_req_o.cyc)
    else $error("dbus cyc held after ack");

endmodule

bind core_top core_assertions assertions_i (.*);

//--- sim/core_tb.sv
/*
 * Testbench for the RV32I integer core
 * Clock and reset, Wishbone memory models with random ack delay,
 * instruction encoder, architectural reference model, store comparison
 */
`timescale 1ns/1ps

module core_tb;

  import core_pkg::*;

  localparam int NUM_TESTS = 6;
  localparam int MAX_LEN   = 48;
  // Extra fetches past the program so the pipeline drains
  localparam int DRAIN     = 4;

  logic    clk            = 1'b0;
  logic    rst_n          = 1'b0;
  logic    fetch_enable   = 1'b0;
  wb_req_t ibus_req;
  wb_rsp_t ibus_rsp       = '0;
  wb_req_t dbus_req;
  wb_rsp_t dbus_rsp       = '0;

  word_t   prog [NUM_TESTS][MAX_LEN];
  int      prog_len [NUM_TESTS];
  string   test_name [NUM_TESTS];
  int      cur_test       = 0;
  logic    programs_ready = 1'b0;

  // Expected and observed stores
  word_t   exp_adr [$];
  word_t   exp_dat [$];
  wb_req_t got_q [$];
  int      cmp_idx        = 0;

  int      fetch_count    = 0;
  word_t   fetch_next     = '0;
  int      errors         = 0;
  int      tests_passed   = 0;

  // Bus model state
  logic    ib_busy        = 1'b0;
  int      ib_wait        = 0;
  logic    db_busy        = 1'b0;
  int      db_wait        = 0;

  core_top dut_i (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .fetch_enable_i ( fetch_enable ),
    .ibus_req_o     ( ibus_req     ),
    .ibus_rsp_i     ( ibus_rsp     ),
    .dbus_req_o     ( dbus_req     ),
    .dbus_rsp_i     ( dbus_rsp     )
  );

  initial begin
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // Instruction encoder
  ////////////////////////////////////////

  function automatic word_t enc_r(int f7, int f3, int rd, int rs1, int rs2);
    instr_u u;
    u.r_type.funct7 = f7[6:0];
    u.r_type.rs2    = rs2[4:0];
    u.r_type.rs1    = rs1[4:0];
    u.r_type.funct3 = f3[2:0];
    u.r_type.rd     = rd[4:0];
    u.r_type.opcode = OPC_OP;
    return u;
  endfunction

  function automatic word_t enc_i(int f3, int rd, int rs1, int imm);
    instr_u u;
    u.i_type.imm    = imm[11:0];
    u.i_type.rs1    = rs1[4:0];
    u.i_type.funct3 = f3[2:0];
    u.i_type.rd     = rd[4:0];
    u.i_type.opcode = OPC_OP_IMM;
    return u;
  endfunction

  // Upper 20 bits split over the I view fields
  function automatic word_t enc_lui(int rd, int imm20);
    instr_u u;
    u.i_type.imm    = imm20[19:8];
    u.i_type.rs1    = imm20[7:3];
    u.i_type.funct3 = imm20[2:0];
    u.i_type.rd     = rd[4:0];
    u.i_type.opcode = OPC_LUI;
    return u;
  endfunction

  function automatic word_t enc_sw(int rs2, int rs1, int imm);
    instr_u u;
    u.s_type.imm_hi = imm[11:5];
    u.s_type.rs2    = rs2[4:0];
    u.s_type.rs1    = rs1[4:0];
    u.s_type.funct3 = FUNCT3_SW;
    u.s_type.imm_lo = imm[4:0];
    u.s_type.opcode = OPC_STORE;
    return u;
  endfunction

  task automatic add_instr(int t, word_t w);
    prog[t][prog_len[t]] = w;
    prog_len[t]++;
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Runs program t on architectural state, fills the expected stores
  function automatic int ref_run(int t);
    word_t       x [32];
    word_t       w;
    word_t       res;
    word_t       imm_i;
    word_t       imm_s;
    logic        wr;
    logic [6:0]  f7;
    logic [2:0]  f3;
    int          rd;
    int          rs1;
    int          rs2;
    for (int r = 0; r < 32; r++) begin
      x[r] = '0;
    end
    exp_adr.delete();
    exp_dat.delete();
    for (int pc = 0; pc < prog_len[t]; pc++) begin
      w     = prog[t][pc];
      f7    = w[31:25];
      f3    = w[14:12];
      rd    = int'(w[11:7]);
      rs1   = int'(w[19:15]);
      rs2   = int'(w[24:20]);
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      res   = '0;
      wr    = 1'b0;
      case (w[6:0])
        7'b0110011: begin
          if (f7 == 7'h00) begin
            wr = 1'b1;
            case (f3)
              3'd0:    res = x[rs1] + x[rs2];
              3'd4:    res = x[rs1] ^ x[rs2];
              3'd6:    res = x[rs1] | x[rs2];
              3'd7:    res = x[rs1] & x[rs2];
              default: wr = 1'b0;
            endcase
          end else if (f7 == 7'h20 && f3 == 3'd0) begin
            wr  = 1'b1;
            res = x[rs1] - x[rs2];
          end
        end
        7'b0010011: begin
          wr = 1'b1;
          case (f3)
            3'd0:    res = x[rs1] + imm_i;
            3'd4:    res = x[rs1] ^ imm_i;
            3'd6:    res = x[rs1] | imm_i;
            3'd7:    res = x[rs1] & imm_i;
            default: wr = 1'b0;
          endcase
        end
        7'b0110111: begin
          wr  = 1'b1;
          res = {w[31:12], 12'b0};
        end
        7'b0100011: begin
          if (f3 == 3'd2) begin
            exp_adr.push_back(x[rs1] + imm_s);
            exp_dat.push_back(x[rs2]);
          end
        end
        // System and other opcodes do nothing here
        default: ;
      endcase
      if (wr && rd != 0) begin
        x[rd] = res;
      end
    end
    return exp_adr.size();
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_wb_req(string name, wb_req_t got, wb_req_t exp);
    if (got.stb !== exp.stb) begin
      $display("FAIL %0t %s.stb got %b expected %b", $time, name, got.stb, exp.stb);
      errors++;
    end
    if (got.adr !== exp.adr) begin
      $display("FAIL %0t %s.adr got %h expected %h", $time, name, got.adr, exp.adr);
      errors++;
    end
    // Master data only carries a value on a write
    if (exp.we && got.dat !== exp.dat) begin
      $display("FAIL %0t %s.dat got %h expected %h", $time, name, got.dat, exp.dat);
      errors++;
    end
    if (got.we !== exp.we) begin
      $display("FAIL %0t %s.we got %b expected %b", $time, name, got.we, exp.we);
      errors++;
    end
    if (got.sel !== exp.sel) begin
      $display("FAIL %0t %s.sel got %h expected %h", $time, name, got.sel, exp.sel);
      errors++;
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Bus models
  ////////////////////////////////////////

  function automatic word_t fetch_word(word_t adr);
    if (adr[31:2] < 30'(prog_len[cur_test])) begin
      return prog[cur_test][int'(adr[31:2])];
    end
    // ADDI x0,x0,0 past the end
    return enc_i(0, 0, 0, 0);
  endfunction

  // Ack after 0 to 3 wait cycles, one cycle wide
  always @(posedge clk) begin
    if (!rst_n) begin
      ibus_rsp <= '0;
      ib_busy = 1'b0;
    end else if (ibus_rsp.ack) begin
      ibus_rsp.ack <= 1'b0;
      ib_busy = 1'b0;
    end else if (ibus_req.cyc && ibus_req.stb) begin
      if (!ib_busy) begin
        ib_busy = 1'b1;
        ib_wait = int'($urandom % 4);
      end
      if (ib_wait == 0) begin
        ibus_rsp.ack <= 1'b1;
        ibus_rsp.dat <= fetch_word(ibus_req.adr);
      end else begin
        ib_wait--;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      dbus_rsp <= '0;
      db_busy = 1'b0;
    end else if (dbus_rsp.ack) begin
      dbus_rsp.ack <= 1'b0;
      db_busy = 1'b0;
    end else if (dbus_req.cyc && dbus_req.stb) begin
      if (!db_busy) begin
        db_busy = 1'b1;
        db_wait = int'($urandom % 4);
      end
      if (db_wait == 0) begin
        dbus_rsp.ack <= 1'b1;
      end else begin
        db_wait--;
      end
    end
  end

  // Fetch order monitor, full word reads at sequential addresses
  always @(posedge clk) begin
    wb_req_t exp;
    if (rst_n && ibus_req.cyc && ibus_rsp.ack) begin
      exp     = '0;
      exp.cyc = 1'b1;
      exp.stb = 1'b1;
      exp.we  = 1'b0;
      exp.adr = fetch_next;
      exp.sel = 4'hF;
      check_wb_req("ibus_req", ibus_req, exp);
      fetch_next = fetch_next + 32'd4;
      fetch_count++;
    end
  end

  // Store monitor, sampled on the ack edge
  always @(posedge clk) begin
    if (rst_n && dbus_req.cyc && dbus_rsp.ack) begin
      got_q.push_back(dbus_req);
    end
  end

  // Comparison process
  initial begin
    wb_req_t got;
    wb_req_t exp;
    forever begin
      @(negedge clk);
      while (got_q.size() > 0) begin
        got = got_q.pop_front();
        if (cmp_idx < exp_adr.size()) begin
          exp     = '0;
          exp.cyc = 1'b1;
          exp.stb = 1'b1;
          exp.we  = 1'b1;
          exp.adr = exp_adr[cmp_idx];
          exp.dat = exp_dat[cmp_idx];
          exp.sel = 4'hF;
          check_wb_req("dbus_req", got, exp);
        end else begin
          $display("Store to %h seen after all expected stores", got.adr);
          errors++;
        end
        cmp_idx++;
      end
    end
  end

  ////////////////////////////////////////
  // Programs
  ////////////////////////////////////////

  task automatic build_programs();
    int sel;
    for (int t = 0; t < NUM_TESTS; t++) begin
      prog_len[t] = 0;
    end
    test_name[0] = "fetch_order";
    add_instr(0, enc_i(0, 1, 0, 5));
    add_instr(0, enc_sw(1, 0, 0));
    add_instr(0, enc_sw(1, 1, 8));
    test_name[1] = "r_type_ops";
    add_instr(1, enc_lui(1, 20'h12345));
    add_instr(1, enc_i(0, 1, 1, 12'h678));
    add_instr(1, enc_lui(2, 20'h0F0F1));
    add_instr(1, enc_i(0, 2, 2, -241));
    add_instr(1, enc_r(0, 0, 3, 1, 2));
    add_instr(1, enc_sw(3, 0, 0));
    add_instr(1, enc_r(32, 0, 4, 1, 2));
    add_instr(1, enc_sw(4, 0, 4));
    add_instr(1, enc_r(0, 7, 5, 1, 2));
    add_instr(1, enc_sw(5, 0, 8));
    add_instr(1, enc_r(0, 6, 6, 1, 2));
    add_instr(1, enc_sw(6, 0, 12));
    add_instr(1, enc_r(0, 4, 7, 1, 2));
    add_instr(1, enc_sw(7, 0, 16));
    // Negative immediates, sign extension, LUI
    test_name[2] = "immediates";
    add_instr(2, enc_i(0, 5, 0, -1));
    add_instr(2, enc_sw(5, 0, -4));
    add_instr(2, enc_i(4, 6, 5, 12'h555));
    add_instr(2, enc_sw(6, 5, -2048));
    add_instr(2, enc_i(6, 7, 0, -2048));
    add_instr(2, enc_sw(7, 0, 2047));
    add_instr(2, enc_i(7, 8, 5, -16));
    add_instr(2, enc_lui(9, 20'hFFFFF));
    add_instr(2, enc_sw(8, 9, 100));
    add_instr(2, enc_sw(9, 8, -20));
    // Each instruction reads the one just before
    test_name[3] = "forwarding";
    add_instr(3, enc_i(0, 1, 1, 1));
    add_instr(3, enc_i(0, 1, 1, 2));
    add_instr(3, enc_r(0, 0, 2, 1, 1));
    add_instr(3, enc_r(32, 0, 3, 2, 1));
    add_instr(3, enc_sw(3, 2, 0));
    add_instr(3, enc_lui(4, 20'hABCDE));
    add_instr(3, enc_r(0, 4, 4, 4, 3));
    add_instr(3, enc_sw(4, 4, 4));
    add_instr(3, enc_sw(1, 3, 0));
    test_name[4] = "x0_writes";
    add_instr(4, enc_i(0, 0, 0, 123));
    add_instr(4, enc_lui(0, 20'h55555));
    add_instr(4, enc_i(0, 1, 0, 77));
    add_instr(4, enc_r(0, 0, 0, 1, 1));
    add_instr(4, enc_sw(0, 0, 16));
    add_instr(4, enc_r(0, 0, 2, 0, 1));
    add_instr(4, enc_sw(2, 0, 20));
    // Random mix over x0 to x7, one ECALL as a no-op
    test_name[5] = "random_delays";
    for (int i = 0; i < 30; i++) begin
      sel = int'($urandom % 8);
      case (sel)
        0: add_instr(5, enc_r(0, 0, int'($urandom % 8), int'($urandom % 8),
                              int'($urandom % 8)));
        1: add_instr(5, enc_r(32, 0, int'($urandom % 8), int'($urandom % 8),
                              int'($urandom % 8)));
        2: add_instr(5, enc_r(0, 7, int'($urandom % 8), int'($urandom % 8),
                              int'($urandom % 8)));
        3: add_instr(5, enc_r(0, 6, int'($urandom % 8), int'($urandom % 8),
                              int'($urandom % 8)));
        4: add_instr(5, enc_r(0, 4, int'($urandom % 8), int'($urandom % 8),
                              int'($urandom % 8)));
        5: add_instr(5, enc_i(int'($urandom % 2) * 4, int'($urandom % 8),
                              int'($urandom % 8), int'($urandom % 4096)));
        6: add_instr(5, enc_lui(int'($urandom % 8), int'($urandom % 1048576)));
        default: add_instr(5, enc_sw(int'($urandom % 8), int'($urandom % 8),
                                     int'($urandom % 4096)));
      endcase
    end
    add_instr(5, 32'h0000_0073);
    for (int r = 1; r < 8; r++) begin
      add_instr(5, enc_sw(r, 0, 4 * r));
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  task automatic run_test(int t);
    int n_exp;
    int err_start;
    int cycles;
    err_start = errors;
    @(posedge clk);
    rst_n        <= 1'b0;
    fetch_enable <= 1'b0;
    repeat (10) @(posedge clk);
    cur_test    = t;
    n_exp       = ref_run(t);
    cmp_idx     = 0;
    fetch_count = 0;
    fetch_next  = BOOT_ADDR;
    got_q.delete();
    rst_n <= 1'b1;
    // Nothing may start while fetch is disabled
    repeat (4) begin
      @(negedge clk);
      if (ibus_req.cyc || dbus_req.cyc) begin
        $display("Bus cycle started at %0t before fetch enable", $time);
        errors++;
      end
    end
    @(posedge clk);
    fetch_enable <= 1'b1;
    cycles = 0;
    while (fetch_count < prog_len[t] + DRAIN && cycles < 40 * (prog_len[t] + DRAIN)) begin
      @(posedge clk);
      cycles++;
    end
    if (fetch_count < prog_len[t] + DRAIN) begin
      $display("Test %s timed out waiting for fetches", test_name[t]);
      errors++;
    end
    repeat (2) @(negedge clk);
    check_count("store_count", cmp_idx, n_exp);
    if (errors == err_start) begin
      tests_passed++;
      $display("Test %s passed, %0d stores", test_name[t], n_exp);
    end else begin
      $display("Test %s failed, %0d errors", test_name[t], errors - err_start);
    end
  endtask

  initial begin
    void'($urandom(86221));
    build_programs();
    programs_ready = 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Tests passed %0d of %0d, errors %0d", tests_passed, NUM_TESTS, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog, 40 cycles per instruction plus reset and idle per test
  initial begin
    int total;
    wait (programs_ready);
    total = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total += 40 * (prog_len[t] + DRAIN) + 30;
    end
    repeat (total) @(posedge clk);
    $display("Watchdog expired after %0d cycles, run did not finish", total);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
